// ==== lm80c_pkg.sv ====
////////////////////////////////////////
// LM80C glue core shared definitions
// Widths, I/O map, boot signature, FSM states
////////////////////////////////////////

package lm80c_pkg;

	localparam int ADDR_W       = 16;  // Z80 address bus
	localparam int DATA_W       = 8;   // Byte wide everything
	localparam int IO_DEV_COUNT = 5;   // PIO, CTC, SIO, VDP, PSG

	typedef logic [ADDR_W-1:0]       addr_t;
	typedef logic [DATA_W-1:0]       data_t;
	typedef logic [IO_DEV_COUNT-1:0] io_sel_t;  // Bit 0 PIO .. bit 4 PSG

	// Audio widths
	typedef logic [7:0] chan_t;  // One PSG channel
	typedef logic [9:0] mix_t;   // Three channels, no overflow

	// Expected first four ROM bytes, address 0 in the top byte
	localparam logic [31:0] BOOT_SIG = 32'hF3C3_5A02;

	localparam data_t ERASE_FILL = 8'h00;

	typedef enum logic [1:0] {
		CHK_IDLE,  // Waiting for CPU reset release
		CHK_READ,  // Read request pending
		CHK_WAIT,  // Waiting for read data
		CHK_DONE   // Publish result
	} checker_state_t;

	typedef enum logic {
		ERS_IDLE,
		ERS_SWEEP  // Writing fill byte
	} eraser_state_t;

endpackage

// ==== mem_req_if.sv ====
////////////////////////////////////////
// Valid/ready byte memory request bus
////////////////////////////////////////
`timescale 1ns/10ps

interface mem_req_if import lm80c_pkg::*; ();

	logic  valid;   // Request pending
	logic  we;      // 1 write, 0 read
	addr_t addr;
	data_t wdata;
	logic  ready;   // Accepted when valid & ready
	data_t rdata;   // Read byte, qualified by rvalid
	logic  rvalid;  // One cycle after read acceptance

	modport requester (output valid, we, addr, wdata, input ready, rdata, rvalid);

	// Memory side, also used by the arbiter towards each requester
	modport memory (input valid, we, addr, wdata, output ready, rdata, rvalid);

endinterface

// ==== z80_bus_decoder.sv ====
////////////////////////////////////////
// Z80 bus decoder
// I/O selects, one memory request per strobe,
// CPU read data mux
////////////////////////////////////////
`timescale 1ns/10ps

module z80_bus_decoder import lm80c_pkg::*; (
	input  logic    CLOCK,
	input  logic    arst_n_i,
	input  addr_t   cpu_addr_i,
	input  data_t   cpu_data_i,
	input  logic    cpu_mreq_n_i,
	input  logic    cpu_iorq_n_i,
	input  logic    cpu_rd_n_i,
	input  logic    cpu_wr_n_i,
	input  data_t   io_rdata_i,
	output io_sel_t io_sel_o,
	output data_t   cpu_data_o,
	mem_req_if.requester mem
);

	logic  io_cycle, io_rd;
	logic  mem_strobe, strobe_q, strobe_start;
	logic  rom_wr;    // Write into ROM area, dropped
	logic  pend_q;    // Request lost arbitration, keep asking
	data_t rdata_q;   // Last byte read from RAM

	assign io_cycle = ~cpu_iorq_n_i;
	assign io_rd    = io_cycle & ~cpu_rd_n_i;

	// Peripheral select from A[7:4], nibbles 5..15 unused
	always_comb begin
		io_sel_o = '0;
		if (io_cycle && (cpu_addr_i[7:4] < IO_DEV_COUNT)) begin
			io_sel_o = io_sel_t'(1) << cpu_addr_i[7:4];
		end
	end

	assign mem_strobe   = ~cpu_mreq_n_i & (~cpu_rd_n_i | ~cpu_wr_n_i);
	assign strobe_start = mem_strobe & ~strobe_q;  // First cycle only
	assign rom_wr       = ~cpu_wr_n_i & ~cpu_addr_i[15];

	assign mem.valid = (strobe_start & ~rom_wr) | pend_q;
	assign mem.we    = ~cpu_wr_n_i;
	assign mem.addr  = cpu_addr_i;   // CPU holds bus during strobe
	assign mem.wdata = cpu_data_i;

	always_ff @(posedge CLOCK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			strobe_q <= 1'b0;
			pend_q   <= 1'b0;
		end else begin
			strobe_q <= mem_strobe;
			pend_q   <= mem.valid & ~mem.ready;  // Drops once accepted
		end
	end

	always_ff @(posedge CLOCK) begin
		if (mem.rvalid) begin
			rdata_q <= mem.rdata;
		end
	end

	assign cpu_data_o = io_rd ? io_rdata_i : rdata_q;  // I/O path stays combinational

	a_io_sel_onehot: assert property (@(posedge CLOCK) disable iff (!arst_n_i)
		$onehot0(io_sel_o));

endmodule

// ==== ram_arbiter.sv ====
////////////////////////////////////////
// Fixed priority RAM arbiter
// Loader > eraser > checker > CPU
////////////////////////////////////////
`timescale 1ns/10ps

module ram_arbiter (
	input  logic CLOCK,
	input  logic arst_n_i,
	mem_req_if.memory    load_m,
	mem_req_if.memory    erase_m,
	mem_req_if.memory    check_m,
	mem_req_if.memory    cpu_m,
	mem_req_if.requester ram_m
);

	logic [3:0] req_vld;  // Bit 0 loader .. bit 3 CPU
	logic [3:0] gnt;      // One-hot winner
	logic [3:0] owner_q;  // Who waits for rdata

	assign req_vld = {cpu_m.valid, check_m.valid, erase_m.valid, load_m.valid};
	assign gnt     = req_vld & (~req_vld + 4'd1);  // Lowest set bit wins

	// Forward winner onto RAM port
	always_comb begin
		ram_m.valid = |req_vld;
		if (gnt[0]) begin
			ram_m.we    = load_m.we;
			ram_m.addr  = load_m.addr;
			ram_m.wdata = load_m.wdata;
		end else if (gnt[1]) begin
			ram_m.we    = erase_m.we;
			ram_m.addr  = erase_m.addr;
			ram_m.wdata = erase_m.wdata;
		end else if (gnt[2]) begin
			ram_m.we    = check_m.we;
			ram_m.addr  = check_m.addr;
			ram_m.wdata = check_m.wdata;
		end else begin
			ram_m.we    = cpu_m.we;
			ram_m.addr  = cpu_m.addr;
			ram_m.wdata = cpu_m.wdata;
		end
	end

	assign load_m.ready  = ram_m.ready & gnt[0];  // Losers just hold valid
	assign erase_m.ready = ram_m.ready & gnt[1];
	assign check_m.ready = ram_m.ready & gnt[2];
	assign cpu_m.ready   = ram_m.ready & gnt[3];

	always_ff @(posedge CLOCK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			owner_q <= '0;
		end else if (ram_m.valid && ram_m.ready && !ram_m.we) begin
			owner_q <= gnt;  // Read accepted, remember requester
		end
	end

	// Read return, data shared and rvalid steered
	assign load_m.rdata   = ram_m.rdata;
	assign erase_m.rdata  = ram_m.rdata;
	assign check_m.rdata  = ram_m.rdata;
	assign cpu_m.rdata    = ram_m.rdata;
	assign load_m.rvalid  = ram_m.rvalid & owner_q[0];
	assign erase_m.rvalid = ram_m.rvalid & owner_q[1];
	assign check_m.rvalid = ram_m.rvalid & owner_q[2];
	assign cpu_m.rvalid   = ram_m.rvalid & owner_q[3];

	a_single_ready: assert property (@(posedge CLOCK) disable iff (!arst_n_i)
		$onehot0({load_m.ready, erase_m.ready, check_m.ready, cpu_m.ready}));

endmodule

// ==== block_ram.sv ====
////////////////////////////////////////
// On-chip byte RAM
// Always ready, read data one cycle later
////////////////////////////////////////
`timescale 1ns/10ps

module block_ram import lm80c_pkg::*; #(
	parameter int MEM_ADDR_W = 12
) (
	input  logic CLOCK,
	mem_req_if.memory mem
);

	data_t ram_q [2**MEM_ADDR_W];
	logic  accept;
	logic  [MEM_ADDR_W-1:0] idx;  // Upper address bits alias

	assign mem.ready = 1'b1;  // No back-pressure from RAM
	assign accept    = mem.valid & mem.ready;
	assign idx       = mem.addr[MEM_ADDR_W-1:0];

	always_ff @(posedge CLOCK) begin
		if (accept && mem.we) begin
			ram_q[idx] <= mem.wdata;
		end
		if (accept && !mem.we) begin
			mem.rdata <= ram_q[idx];
		end
		mem.rvalid <= accept & ~mem.we;  // One cycle read pulse
	end

endmodule

// ==== ram_eraser.sv ====
////////////////////////////////////////
// RAM eraser
// Writes the fill byte to every location
////////////////////////////////////////
`timescale 1ns/10ps

module ram_eraser import lm80c_pkg::*; #(
	parameter int MEM_ADDR_W = 12
) (
	input  logic CLOCK,
	input  logic arst_n_i,
	input  logic start_i,
	output logic busy_o,
	mem_req_if.requester mem
);

	eraser_state_t state_q;
	logic [MEM_ADDR_W-1:0] addr_q;  // Sweep pointer

	always_ff @(posedge CLOCK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ERS_IDLE;
			addr_q  <= '0;
		end else begin
			case (state_q)
				ERS_IDLE: if (start_i) begin
					state_q <= ERS_SWEEP;
					addr_q  <= '0;
				end
				ERS_SWEEP: if (mem.ready) begin  // Start pulses ignored here
					addr_q <= addr_q + 1'b1;
					if (&addr_q) begin
						state_q <= ERS_IDLE;  // Last location written
					end
				end
				default: state_q <= ERS_IDLE;
			endcase
		end
	end

	assign busy_o    = (state_q == ERS_SWEEP);
	assign mem.valid = busy_o;
	assign mem.we    = 1'b1;
	assign mem.addr  = addr_t'(addr_q);
	assign mem.wdata = ERASE_FILL;

endmodule

// ==== boot_checker.sv ====
////////////////////////////////////////
// Boot signature checker
// Reads bytes 0..3 after CPU reset release
////////////////////////////////////////
`timescale 1ns/10ps

module boot_checker import lm80c_pkg::*; (
	input  logic CLOCK,
	input  logic arst_n_i,
	input  logic cpu_reset_n_i,
	output logic busy_o,
	output logic boot_ok_o,
	mem_req_if.requester mem
);

	checker_state_t state_q;
	logic       rst_q;    // Previous reset level
	logic       rise;
	logic [1:0] idx_q;    // Byte being checked
	logic [2:0] hits_q;   // Matching bytes so far
	data_t      sig_byte;

	assign rise     = cpu_reset_n_i & ~rst_q;
	assign sig_byte = BOOT_SIG[(3 - idx_q) * DATA_W +: DATA_W];  // Byte 0 is MSB

	always_ff @(posedge CLOCK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= CHK_IDLE;
			rst_q     <= 1'b0;
			idx_q     <= '0;
			hits_q    <= '0;
			boot_ok_o <= 1'b0;
		end else begin
			rst_q <= cpu_reset_n_i;
			case (state_q)
				CHK_IDLE: if (rise) begin
					state_q <= CHK_READ;
					idx_q   <= '0;
					hits_q  <= '0;
				end
				CHK_READ: if (mem.ready) begin
					state_q <= CHK_WAIT;
				end
				CHK_WAIT: if (mem.rvalid) begin
					if (mem.rdata == sig_byte) begin
						hits_q <= hits_q + 3'd1;
					end
					idx_q   <= idx_q + 2'd1;
					state_q <= (idx_q == 2'd3) ? CHK_DONE : CHK_READ;
				end
				CHK_DONE: begin
					boot_ok_o <= (hits_q == 3'd4);  // All four must match
					state_q   <= CHK_IDLE;
				end
				default: state_q <= CHK_IDLE;
			endcase
		end
	end

	// Busy already in the release cycle so the CPU never slips through
	assign busy_o    = (state_q != CHK_IDLE) | rise;
	assign mem.valid = (state_q == CHK_READ);
	assign mem.we    = 1'b0;
	assign mem.addr  = addr_t'(idx_q);
	assign mem.wdata = '0;

endmodule

// ==== audio_mixer_dac.sv ====
////////////////////////////////////////
// Audio mixer and 1st order sigma-delta DAC
////////////////////////////////////////
`timescale 1ns/10ps

module audio_mixer_dac import lm80c_pkg::*; (
	input  logic  CLOCK,
	input  logic  arst_n_i,
	input  chan_t chan_a_i,
	input  chan_t chan_b_i,
	input  chan_t chan_c_i,
	output logic  audio_o
);

	mix_t mix;
	mix_t acc_q;                   // Error accumulator
	logic [$bits(mix_t):0] sum;    // Extra bit is the output pulse

	// Three 8 bit channels, max 765, fits in 10 bits
	assign mix = mix_t'(chan_a_i) + mix_t'(chan_b_i) + mix_t'(chan_c_i);
	assign sum = {1'b0, acc_q} + {1'b0, mix};

	always_ff @(posedge CLOCK or negedge arst_n_i) begin
		if (!arst_n_i) begin
			acc_q   <= '0;
			audio_o <= 1'b0;
		end else begin
			acc_q   <= sum[$bits(mix_t)-1:0];
			audio_o <= sum[$bits(mix_t)];  // Density = mix / 1024
		end
	end

endmodule

// ==== lm80c_system_core.sv ====
////////////////////////////////////////
// LM80C system glue core
// CPU bus decode, shared RAM, eraser,
// boot check, audio DAC, reset control
////////////////////////////////////////
`timescale 1ns/10ps

module lm80c_system_core import lm80c_pkg::*; #(
	parameter int MEM_ADDR_W = 12  // 4 KiB RAM
) (
	input  logic    CLOCK,
	input  logic    arst_n_i,
	input  logic    load_valid_i,   // Loader write port
	input  addr_t   load_addr_i,
	input  data_t   load_data_i,
	input  logic    load_busy_i,
	input  logic    load_done_i,
	output logic    load_ready_o,
	input  logic    erase_start_i,
	input  addr_t   cpu_addr_i,     // Z80 bus
	input  data_t   cpu_data_i,
	input  logic    cpu_mreq_n_i,
	input  logic    cpu_iorq_n_i,
	input  logic    cpu_rd_n_i,
	input  logic    cpu_wr_n_i,
	output data_t   cpu_data_o,
	output logic    cpu_ena_o,
	output logic    cpu_reset_n_o,
	output io_sel_t io_sel_o,
	input  data_t   io_rdata_i,
	input  logic    reset_key_i,
	input  chan_t   chan_a_i,
	input  chan_t   chan_b_i,
	input  chan_t   chan_c_i,
	output logic    audio_o,
	output logic    boot_ok_o
);

	logic erase_busy, check_busy;

	mem_req_if cpu_if ();
	mem_req_if load_if ();
	mem_req_if erase_if ();
	mem_req_if check_if ();
	mem_req_if ram_if ();

	// CPU held in reset while booting or key pressed
	assign cpu_reset_n_o = load_done_i & ~reset_key_i;
	assign cpu_ena_o     = cpu_reset_n_o & ~load_busy_i & ~erase_busy & ~check_busy;

	// Loader only writes
	assign load_if.valid = load_valid_i;
	assign load_if.we    = 1'b1;
	assign load_if.addr  = load_addr_i;
	assign load_if.wdata = load_data_i;
	assign load_ready_o  = load_if.ready;

	z80_bus_decoder i_z80_bus_decoder (
		.CLOCK        (CLOCK),
		.arst_n_i     (arst_n_i),
		.cpu_addr_i   (cpu_addr_i),
		.cpu_data_i   (cpu_data_i),
		.cpu_mreq_n_i (cpu_mreq_n_i),
		.cpu_iorq_n_i (cpu_iorq_n_i),
		.cpu_rd_n_i   (cpu_rd_n_i),
		.cpu_wr_n_i   (cpu_wr_n_i),
		.io_rdata_i   (io_rdata_i),
		.io_sel_o     (io_sel_o),
		.cpu_data_o   (cpu_data_o),
		.mem          (cpu_if.requester)
	);

	ram_arbiter i_ram_arbiter (
		.CLOCK    (CLOCK),
		.arst_n_i (arst_n_i),
		.load_m   (load_if.memory),
		.erase_m  (erase_if.memory),
		.check_m  (check_if.memory),
		.cpu_m    (cpu_if.memory),
		.ram_m    (ram_if.requester)
	);

	block_ram #(.MEM_ADDR_W(MEM_ADDR_W)) i_block_ram (
		.CLOCK (CLOCK),
		.mem   (ram_if.memory)
	);

	ram_eraser #(.MEM_ADDR_W(MEM_ADDR_W)) i_ram_eraser (
		.CLOCK    (CLOCK),
		.arst_n_i (arst_n_i),
		.start_i  (erase_start_i),
		.busy_o   (erase_busy),
		.mem      (erase_if.requester)
	);

	boot_checker i_boot_checker (
		.CLOCK         (CLOCK),
		.arst_n_i      (arst_n_i),
		.cpu_reset_n_i (cpu_reset_n_o),
		.busy_o        (check_busy),
		.boot_ok_o     (boot_ok_o),
		.mem           (check_if.requester)
	);

	audio_mixer_dac i_audio_mixer_dac (
		.CLOCK    (CLOCK),
		.arst_n_i (arst_n_i),
		.chan_a_i (chan_a_i),
		.chan_b_i (chan_b_i),
		.chan_c_i (chan_c_i),
		.audio_o  (audio_o)
	);

endmodule

// ==== tb_lm80c_system_core.sv ====
////////////////////////////////////////
// LM80C glue core testbench
// Directed tests for boot check, RAM, I/O,
// eraser, reset key and audio DAC
////////////////////////////////////////
`timescale 1ns/10ps

module tb_lm80c_system_core import lm80c_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 10;
	localparam int MEM_ADDR_W   = 12;
	localparam int SETTLE       = 32;    // Audio accumulator settling
	localparam int AUDIO_CYCLES = 1024;  // One full accumulator wrap
	localparam logic [31:0] RAND_SEED = 32'ha044_1297;
	// Erase sweep dominates, the rest is a few hundred cycles
	localparam int TEST_CYCLES  = RESET_CYCLES + 2**MEM_ADDR_W + SETTLE + AUDIO_CYCLES + 600;

	logic    CLOCK, arst_n_i;
	logic    load_valid_i, load_busy_i, load_done_i, load_ready_o;
	addr_t   load_addr_i;
	data_t   load_data_i;
	logic    erase_start_i;
	addr_t   cpu_addr_i;
	data_t   cpu_data_i, cpu_data_o;
	logic    cpu_mreq_n_i, cpu_iorq_n_i, cpu_rd_n_i, cpu_wr_n_i;
	logic    cpu_ena_o, cpu_reset_n_o;
	io_sel_t io_sel_o;
	data_t   io_rdata_i;
	logic    reset_key_i;
	chan_t   chan_a_i, chan_b_i, chan_c_i;
	logic    audio_o, boot_ok_o;

	int    errors = 0;
	int    checks = 0;
	data_t ref_bytes [16];  // Loaded at 0x0100..0x010F
	data_t boot_bytes [4] = '{8'hF3, 8'hC3, 8'h5A, 8'h02};

	lm80c_system_core #(.MEM_ADDR_W(MEM_ADDR_W)) i_lm80c_system_core (.*);

	initial begin
		CLOCK = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK = ~CLOCK;
	end

	// Watchdog, twice the expected run length
	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("Watchdog timeout, run still going after %0d cycles", 2 * TEST_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	task automatic check_data(input string name, input data_t exp, input data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_sel(input string name, input io_sel_t exp, input io_sel_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// Loader write, held until the arbiter grants it
	task automatic load_byte(input addr_t a, input data_t d);
		@(posedge CLOCK);
		load_valid_i <= 1'b1;
		load_addr_i  <= a;
		load_data_i  <= d;
		@(negedge CLOCK);
		while (!load_ready_o) @(negedge CLOCK);
		@(posedge CLOCK);  // Accept edge
		load_valid_i <= 1'b0;
	endtask

	task automatic cpu_read(input addr_t a, output data_t d);
		@(posedge CLOCK);
		cpu_addr_i   <= a;
		cpu_mreq_n_i <= 1'b0;
		cpu_rd_n_i   <= 1'b0;
		repeat (2) @(posedge CLOCK);  // Byte due 2 cycles after strobe
		@(negedge CLOCK);
		d = cpu_data_o;
		@(posedge CLOCK);
		cpu_mreq_n_i <= 1'b1;
		cpu_rd_n_i   <= 1'b1;
	endtask

	task automatic cpu_write(input addr_t a, input data_t d);
		@(posedge CLOCK);
		cpu_addr_i   <= a;
		cpu_data_i   <= d;
		cpu_mreq_n_i <= 1'b0;
		cpu_wr_n_i   <= 1'b0;
		repeat (2) @(posedge CLOCK);
		cpu_mreq_n_i <= 1'b1;
		cpu_wr_n_i   <= 1'b1;
	endtask

	// Counts cycles with the CPU stopped, gives up after max_cycles
	task automatic wait_cpu_ena(input string name, input int max_cycles, output int n);
		n = 0;
		@(negedge CLOCK);
		while (!cpu_ena_o && n < max_cycles) begin
			n++;
			@(negedge CLOCK);
		end
		if (!cpu_ena_o) begin
			errors++;
			$display("%s: CPU enable still low after %0d cycles", name, n);
		end
	endtask

	task automatic test_boot();
		int n;
		@(posedge CLOCK);
		load_busy_i <= 1'b1;
		for (int i = 0; i < 4; i++) load_byte(addr_t'(i), boot_bytes[i]);
		for (int i = 0; i < 16; i++) begin
			ref_bytes[i] = data_t'($urandom_range(255, 1));  // Never the zero fill byte
			load_byte(addr_t'(16'h0100 + i), ref_bytes[i]);
		end
		@(posedge CLOCK);
		load_busy_i <= 1'b0;
		load_done_i <= 1'b1;  // Releases CPU reset, checker starts
		wait_cpu_ena("boot good", 64, n);
		check_bit("boot good", 1'b1, boot_ok_o);
		// Corrupt third byte with the key held
		@(posedge CLOCK);
		reset_key_i <= 1'b1;
		load_busy_i <= 1'b1;
		load_byte(addr_t'(2), ~boot_bytes[2]);
		@(posedge CLOCK);
		load_busy_i <= 1'b0;
		reset_key_i <= 1'b0;
		wait_cpu_ena("boot bad", 64, n);
		check_bit("boot bad", 1'b0, boot_ok_o);
	endtask

	task automatic test_memory();
		data_t rd, wb;
		for (int i = 0; i < 16; i++) begin
			cpu_read(addr_t'(16'h0100 + i), rd);
			check_data("mem read", ref_bytes[i], rd);
		end
		do begin
			wb = data_t'($urandom());
		end while (wb == ref_bytes[0] || wb == ERASE_FILL);  // New byte must be visible
		cpu_write(16'h8100, wb);
		cpu_read(16'h8100, rd);
		check_data("mem write 8100", wb, rd);
		cpu_read(16'h0100, rd);  // 0x8100 aliases onto 0x0100
		check_data("mem alias 0100", wb, rd);
		ref_bytes[0] = wb;
		cpu_write(16'h0101, ~ref_bytes[1]);  // ROM area, must be dropped
		cpu_read(16'h0101, rd);
		check_data("rom protect 0101", ref_bytes[1], rd);
	endtask

	task automatic test_io();
		io_sel_t exp_sel;
		data_t   r;
		for (int n = 0; n < 16; n++) begin
			exp_sel = (n < 5) ? io_sel_t'(1 << n) : '0;  // PIO..PSG only
			r = data_t'($urandom());
			@(posedge CLOCK);
			cpu_addr_i   <= addr_t'(n * 16);
			cpu_iorq_n_i <= 1'b0;
			cpu_rd_n_i   <= 1'b0;
			io_rdata_i   <= r;
			@(negedge CLOCK);
			check_sel("io select", exp_sel, io_sel_o);
			check_data("io read", r, cpu_data_o);
			@(posedge CLOCK);
			cpu_iorq_n_i <= 1'b1;
			cpu_rd_n_i   <= 1'b1;
			@(negedge CLOCK);
			check_sel("io idle", '0, io_sel_o);
		end
	endtask

	task automatic test_erase();
		int    n;
		data_t rd;
		@(posedge CLOCK);
		erase_start_i <= 1'b1;
		@(posedge CLOCK);
		erase_start_i <= 1'b0;
		wait_cpu_ena("erase", 2**MEM_ADDR_W + 16, n);
		if (n < 2**MEM_ADDR_W) begin
			errors++;
			$display("erase: CPU enabled again after %0d cycles, before the sweep ended", n);
		end
		for (int i = 0; i < 16; i++) begin
			cpu_read(addr_t'(16'h0100 + i), rd);
			check_data("erase fill", ERASE_FILL, rd);
		end
		for (int i = 0; i < 4; i++) begin
			cpu_read(addr_t'(i), rd);
			check_data("erase fill low", ERASE_FILL, rd);
		end
	endtask

	task automatic test_reset_key();
		int n;
		@(posedge CLOCK);
		reset_key_i <= 1'b1;
		repeat (8) begin
			@(negedge CLOCK);
			check_bit("key cpu reset", 1'b0, cpu_reset_n_o);
			check_bit("key cpu ena", 1'b0, cpu_ena_o);
		end
		// Signature back in place so the release must rerun the checker
		@(posedge CLOCK);
		load_busy_i <= 1'b1;
		for (int i = 0; i < 4; i++) load_byte(addr_t'(i), boot_bytes[i]);
		@(posedge CLOCK);
		load_busy_i <= 1'b0;
		reset_key_i <= 1'b0;
		wait_cpu_ena("key release", 64, n);
		check_bit("boot after key", 1'b1, boot_ok_o);
	endtask

	task automatic test_audio();
		chan_t a, b, c;
		int    ones, exp;
		a = chan_t'($urandom());
		b = chan_t'($urandom());
		c = chan_t'($urandom());
		exp  = int'(a) + int'(b) + int'(c);
		ones = 0;
		@(posedge CLOCK);
		chan_a_i <= a;
		chan_b_i <= b;
		chan_c_i <= c;
		repeat (SETTLE) @(posedge CLOCK);
		repeat (AUDIO_CYCLES) begin
			@(negedge CLOCK);
			if (audio_o) ones++;
		end
		checks++;
		if (ones < exp - 1 || ones > exp + 1) begin
			errors++;
			$display("[ERROR] audio density: expected %0d +/- 1, actual %0d", exp, ones);
		end
	endtask

	initial begin
		arst_n_i      = 1'b0;
		load_valid_i  = 1'b0;
		load_addr_i   = '0;
		load_data_i   = '0;
		load_busy_i   = 1'b0;
		load_done_i   = 1'b0;
		erase_start_i = 1'b0;
		cpu_addr_i    = '0;
		cpu_data_i    = '0;
		cpu_mreq_n_i  = 1'b1;
		cpu_iorq_n_i  = 1'b1;
		cpu_rd_n_i    = 1'b1;
		cpu_wr_n_i    = 1'b1;
		io_rdata_i    = '0;
		reset_key_i   = 1'b0;
		chan_a_i      = '0;
		chan_b_i      = '0;
		chan_c_i      = '0;
		void'($urandom(RAND_SEED));
		repeat (RESET_CYCLES - 1) @(posedge CLOCK);
		@(negedge CLOCK);  // Outputs quiet while in reset
		check_bit("reset cpu ena", 1'b0, cpu_ena_o);
		check_bit("reset cpu reset", 1'b0, cpu_reset_n_o);
		check_bit("reset load ready", 1'b0, load_ready_o);
		check_bit("reset boot ok", 1'b0, boot_ok_o);
		check_bit("reset audio", 1'b0, audio_o);
		@(posedge CLOCK);
		arst_n_i <= 1'b1;
		test_boot();
		test_memory();
		test_io();
		test_erase();
		test_reset_key();
		test_audio();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== list.f ====
lm80c_pkg.sv
mem_req_if.sv
z80_bus_decoder.sv
ram_arbiter.sv
block_ram.sv
ram_eraser.sv
boot_checker.sv
audio_mixer_dac.sv
lm80c_system_core.sv
tb_lm80c_system_core.sv

// ==== Makefile ====
# Verilator build and run of the LM80C glue core testbench

VERILATOR ?= verilator
TOP       ?= tb_lm80c_system_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "Testbench failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
